// ==== design/axil_reg_file.sv ====
`timescale 1ns/10ps

module axil_reg_file (
  input  logic                                           user_clk,
  input  logic                                           reset_i,
  // write address / data / response
  input  logic [ctrl_pkg::ADDR_W-1:0]                    awaddr_i,
  input  logic                                           awvalid_i,
  output logic                                           awready_o,
  input  logic [ctrl_pkg::WORD_W-1:0]                    wdata_i,
  input  logic [ctrl_pkg::WORD_W/8-1:0]                  wstrb_i,
  input  logic                                           wvalid_i,
  output logic                                           wready_o,
  output logic [1:0]                                     bresp_o,
  output logic                                           bvalid_o,
  input  logic                                           bready_i,
  // read address / data
  input  logic [ctrl_pkg::ADDR_W-1:0]                    araddr_i,
  input  logic                                           arvalid_i,
  output logic                                           arready_o,
  output logic [ctrl_pkg::WORD_W-1:0]                    rdata_o,
  output logic [1:0]                                     rresp_o,
  output logic                                           rvalid_o,
  input  logic                                           rready_i,
  // engine side
  input  logic [ctrl_pkg::STATE_NUM-1:0][ctrl_pkg::WORD_W-1:0] state_i,
  output ctrl_pkg::arg_array_t                           args_o,
  output logic                                           cmd_new_o,
  output logic [ctrl_pkg::CMD_W-1:0]                     cmd_code_o,
  output logic                                           wdog_clear_o,
  output logic                                           wdog_start_o
);

  import ctrl_pkg::*;

  localparam int HI = ADDR_W - 1;
  localparam int WIN_LSB = ADDR_LSB + ARG_IDX_W;

  arg_array_t             args_q;
  arg_array_t             status_w;
  logic                   wr_hs, rd_hs;
  logic                   wr_arg_hit, wr_cmd_hit, wr_wdog_hit;
  logic                   rd_arg_hit, rd_status_hit;
  logic [ARG_IDX_W-1:0]   wr_idx, rd_idx;
  logic                   bvalid_q, rvalid_q;
  logic [1:0]             bresp_q, rresp_q;
  logic [WORD_W-1:0]      rdata_q;
  logic [WORD_W-1:0]      rd_data;
  logic [1:0]             rd_resp;
  logic                   cmd_new_q, wdog_clear_q, wdog_start_q;
  logic [CMD_W-1:0]       cmd_code_q;

  //////////////////////////////////////////////////////////////////////
  // handshakes and address decode
  //////////////////////////////////////////////////////////////////////
  assign wr_hs = awvalid_i && wvalid_i && !bvalid_q;  // one cycle accept
  assign rd_hs = arvalid_i && !rvalid_q;

  assign wr_idx        = awaddr_i[WIN_LSB-1:ADDR_LSB];
  assign rd_idx        = araddr_i[WIN_LSB-1:ADDR_LSB];
  assign wr_arg_hit    = (awaddr_i[HI:WIN_LSB] == ARG_BASE[HI:WIN_LSB]);
  assign wr_cmd_hit    = (awaddr_i == CMD_OFFSET);
  assign wr_wdog_hit   = (awaddr_i == WDOG_OFFSET);
  assign rd_arg_hit    = (araddr_i[HI:WIN_LSB] == ARG_BASE[HI:WIN_LSB]);
  assign rd_status_hit = (araddr_i[HI:WIN_LSB] == STATUS_BASE[HI:WIN_LSB]);

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge user_clk) begin
    if (reset_i) begin
      bvalid_q     <= 1'b0;
      cmd_new_q    <= 1'b0;
      wdog_clear_q <= 1'b0;
      wdog_start_q <= 1'b0;
      cmd_code_q   <= '0;
      args_q       <= '0;
    end else begin
      cmd_new_q    <= 1'b0;   // strobes last one cycle
      wdog_clear_q <= 1'b0;
      wdog_start_q <= 1'b0;
      if (bvalid_q && bready_i) bvalid_q <= 1'b0;
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        if (wr_arg_hit) begin
          for (int b = 0; b < WORD_W/8; b++) begin
            if (wstrb_i[b]) args_q[wr_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
        if (wr_cmd_hit) begin
          cmd_new_q  <= 1'b1;
          cmd_code_q <= wdata_i[CMD_W-1:0];
        end
        if (wr_wdog_hit) begin
          wdog_clear_q <= wdata_i[0];
          wdog_start_q <= wdata_i[1];
        end
      end
    end
  end

  always_ff @(posedge user_clk) begin
    if (wr_hs) begin
      bresp_q <= (wr_arg_hit || wr_cmd_hit || wr_wdog_hit) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////
  // status 0 echoes arg 0, then the engine state words, rest zero
  always_comb begin
    status_w    = '0;
    status_w[0] = args_q[0];
    for (int i = 0; i < STATE_NUM; i++) begin
      status_w[i+1] = state_i[i];
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_SLVERR;
    if (rd_status_hit) begin
      rd_data = status_w[rd_idx];
      rd_resp = RESP_OKAY;
    end else if (rd_arg_hit) begin
      rd_data = args_q[rd_idx];
      rd_resp = RESP_OKAY;
    end
  end

  always_ff @(posedge user_clk) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge user_clk) begin
    if (rd_hs) begin
      rdata_q <= rd_data;   // held until rready
      rresp_q <= rd_resp;
    end
  end

  assign awready_o    = wr_hs;
  assign wready_o     = wr_hs;
  assign bvalid_o     = bvalid_q;
  assign bresp_o      = bresp_q;
  assign arready_o    = rd_hs;
  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign rresp_o      = rresp_q;
  assign args_o       = args_q;
  assign cmd_new_o    = cmd_new_q;
  assign cmd_code_o   = cmd_code_q;
  assign wdog_clear_o = wdog_clear_q;
  assign wdog_start_o = wdog_start_q;

endmodule

// ==== design/cmd_launch_delay.sv ====
`timescale 1ns/10ps

module cmd_launch_delay (
  input  logic                        user_clk,
  input  logic                        reset_i,
  input  logic                        cmd_new_i,
  input  logic [ctrl_pkg::WORD_W-1:0] delay_i,
  output logic                        cmd_valid_o
);

  import ctrl_pkg::*;

  logic              pending_q;
  logic [WORD_W-1:0] cnt_q;
  logic              cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  // a new command always reloads, dropping whatever was pending
  always_ff @(posedge user_clk) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else if (cmd_new_i) begin
      pending_q <= 1'b1;
      cnt_q     <= delay_i;
    end else if (pending_q) begin
      if (cnt_zero) begin
        pending_q <= 1'b0;  // launched
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // fires in the cycle the count sits at zero
  assign cmd_valid_o = pending_q && cnt_zero;

endmodule

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

  // bus and register widths
  localparam int WORD_W     = 32;
  localparam int ADDR_W     = 8;
  localparam int ADDR_LSB   = 2;              // byte offset bits inside a word
  localparam int ARG_NUM    = 8;
  localparam int ARG_IDX_W  = $clog2(ARG_NUM);
  localparam int STATE_NUM  = 4;
  localparam int CMD_W      = 8;

  ////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////
  localparam logic [ADDR_W-1:0] ARG_BASE    = 8'h00;  // arg n at 4*n
  localparam logic [ADDR_W-1:0] CMD_OFFSET  = 8'h20;
  localparam logic [ADDR_W-1:0] WDOG_OFFSET = 8'h24;  // bit0 clear, bit1 start
  localparam logic [ADDR_W-1:0] STATUS_BASE = 8'h40;  // status n at 0x40 + 4*n

  // which argument feeds which command field
  localparam int ARG_CMD_IDX   = 1;
  localparam int ARG_DATA0_IDX = 2;
  localparam int ARG_DATA1_IDX = 3;
  localparam int ARG_DELAY_IDX = 4;

  // axi responses
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // watchdog
  localparam int WDOG_CNT_W = 16;
  localparam int WDOG_LIMIT = 64;

  typedef logic [ARG_NUM-1:0][WORD_W-1:0] arg_array_t;

endpackage

// ==== design/reset_watchdog.sv ====
`timescale 1ns/10ps

module reset_watchdog (
  input  logic user_clk,
  input  logic reset_i,
  input  logic clear_i,
  input  logic start_i,
  output logic sys_reset_o
);

  import ctrl_pkg::*;

  logic                  running_q;
  logic [WDOG_CNT_W-1:0] cnt_q;
  logic                  sys_reset_q;
  logic                  at_limit;

  assign at_limit = (cnt_q == WDOG_CNT_W'(WDOG_LIMIT));

  always_ff @(posedge user_clk) begin
    if (reset_i || clear_i) begin     // clear also stops the count
      running_q   <= 1'b0;
      cnt_q       <= '0;
      sys_reset_q <= 1'b0;
    end else if (start_i) begin
      running_q <= 1'b1;
      cnt_q     <= '0;
    end else if (running_q) begin
      if (at_limit) begin
        sys_reset_q <= 1'b1;          // sticky until clear
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign sys_reset_o = sys_reset_q;

endmodule

// ==== design/ssd_ctrl_top.sv ====
`timescale 1ns/10ps

module ssd_ctrl_top (
  input  logic                                           user_clk,
  input  logic                                           reset_i,
  input  logic [ctrl_pkg::ADDR_W-1:0]                    awaddr_i,
  input  logic                                           awvalid_i,
  output logic                                           awready_o,
  input  logic [ctrl_pkg::WORD_W-1:0]                    wdata_i,
  input  logic [ctrl_pkg::WORD_W/8-1:0]                  wstrb_i,
  input  logic                                           wvalid_i,
  output logic                                           wready_o,
  output logic [1:0]                                     bresp_o,
  output logic                                           bvalid_o,
  input  logic                                           bready_i,
  input  logic [ctrl_pkg::ADDR_W-1:0]                    araddr_i,
  input  logic                                           arvalid_i,
  output logic                                           arready_o,
  output logic [ctrl_pkg::WORD_W-1:0]                    rdata_o,
  output logic [1:0]                                     rresp_o,
  output logic                                           rvalid_o,
  input  logic                                           rready_i,
  input  logic [ctrl_pkg::STATE_NUM-1:0][ctrl_pkg::WORD_W-1:0] state_i,
  output logic                                           cmd_valid_o,
  output logic [ctrl_pkg::WORD_W-1:0]                    cmd_o,
  output logic [ctrl_pkg::CMD_W-1:0]                     cmd_code_o,
  output logic [ctrl_pkg::WORD_W-1:0]                    data0_o,
  output logic [ctrl_pkg::WORD_W-1:0]                    data1_o,
  output logic                                           sys_reset_o
);

  import ctrl_pkg::*;

  arg_array_t args_w;
  logic       cmd_new_w;
  logic       wdog_clear_w;
  logic       wdog_start_w;

  axil_reg_file u_regs (
    .user_clk     (user_clk),
    .reset_i      (reset_i),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .state_i      (state_i),
    .args_o       (args_w),
    .cmd_new_o    (cmd_new_w),
    .cmd_code_o   (cmd_code_o),
    .wdog_clear_o (wdog_clear_w),
    .wdog_start_o (wdog_start_w)
  );

  cmd_launch_delay u_launch (
    .user_clk    (user_clk),
    .reset_i     (reset_i),
    .cmd_new_i   (cmd_new_w),
    .delay_i     (args_w[ARG_DELAY_IDX]),
    .cmd_valid_o (cmd_valid_o)
  );

  reset_watchdog u_wdog (
    .user_clk    (user_clk),
    .reset_i     (reset_i),
    .clear_i     (wdog_clear_w),
    .start_i     (wdog_start_w),
    .sys_reset_o (sys_reset_o)
  );

  // command fields follow the argument registers directly
  assign cmd_o   = args_w[ARG_CMD_IDX];
  assign data0_o = args_w[ARG_DATA0_IDX];
  assign data1_o = args_w[ARG_DATA1_IDX];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ssd_ctrl -f sources.f -o sim_tb --Mdir obj_dir

# the simulator exits non-zero on a fatal check, so keep going to the log search
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Test OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// ==== sources.f ====
design/ctrl_pkg.sv
design/axil_reg_file.sv
design/cmd_launch_delay.sv
design/reset_watchdog.sv
design/ssd_ctrl_top.sv
verif/tb_clock_gen.sv
verif/tb_ssd_ctrl.sv

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic user_clk,
  output logic reset_o
);

  localparam time HALF_PERIOD = 20ns;   // 40 ns clock
  localparam int  RESET_CYCLES = 8;

  initial begin
    user_clk = 1'b0;
    forever #(HALF_PERIOD) user_clk = ~user_clk;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge user_clk);
    reset_o <= 1'b0;
  end

endmodule

// ==== verif/tb_ssd_ctrl.sv ====
`timescale 1ns/10ps

module tb_ssd_ctrl;

  import ctrl_pkg::*;

  localparam int WAIT_MAX   = 200;  // cycles before a handshake wait gives up
  localparam int WDOG_SLACK = 8;

  logic                            user_clk, reset;
  logic [ADDR_W-1:0]               awaddr, araddr;
  logic                            awvalid, wvalid, bready, arvalid, rready;
  logic [WORD_W-1:0]               wdata;
  logic [WORD_W/8-1:0]             wstrb;
  logic [STATE_NUM-1:0][WORD_W-1:0] state;
  logic                            awready, wready, bvalid, arready, rvalid;
  logic [1:0]                      bresp, rresp;
  logic [WORD_W-1:0]               rdata, cmd, data0, data1;
  logic [CMD_W-1:0]                cmd_code;
  logic                            cmd_valid, sys_reset;

  int                seed = 82;
  int                errors = 0;
  int unsigned       cyc = 0;
  int unsigned       pulse_cnt = 0;
  logic [WORD_W-1:0] arg_model [ARG_NUM];   // expected argument contents

  tb_clock_gen u_clk (.user_clk(user_clk), .reset_o(reset));

  ssd_ctrl_top DUT (
    .user_clk (user_clk), .reset_i (reset),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .state_i (state), .cmd_valid_o (cmd_valid), .cmd_o (cmd), .cmd_code_o (cmd_code),
    .data0_o (data0), .data1_o (data1), .sys_reset_o (sys_reset)
  );

  always @(posedge user_clk) cyc <= cyc + 1;
  always @(posedge user_clk) if (cmd_valid) pulse_cnt <= pulse_cnt + 1;  // launch monitor

  //////////////////////////////////////////////////////////////////////
  // checking and bus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                             input string what);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_range(input int got, input int lo, input int hi, input string what);
    assert (got >= lo && got <= hi) else begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d to %0d", $time, what, got, lo, hi);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t ns while waiting for %s", $time, what);
    $display("Test FAILED");
    $fatal(1, "wait timed out");
  endtask

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                            input logic [3:0] strb, output logic [1:0] resp,
                            output int unsigned hs_cyc);
    int n;
    @(posedge user_clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!(awready && wready) && n < WAIT_MAX);
    if (!(awready && wready)) report_timeout("the write address and data handshake");
    hs_cyc = cyc;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!bvalid && n < WAIT_MAX);
    if (!bvalid) report_timeout("the write response");
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data,
                           output logic [1:0] resp);
    int n;
    @(posedge user_clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!arready && n < WAIT_MAX);
    if (!arready) report_timeout("the read address handshake");
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!rvalid && n < WAIT_MAX);
    if (!rvalid) report_timeout("the read data");
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic write_arg(input int idx, input logic [WORD_W-1:0] data);
    logic [1:0]  resp;
    int unsigned hs;
    axil_write(ADDR_W'(ARG_BASE + 4 * idx), data, 4'hf, resp, hs);
    check_value(resp, RESP_OKAY, $sformatf("bresp of arg %0d write", idx));
    arg_model[idx] = data;
  endtask

  task automatic read_expect(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] exp,
                             input logic [1:0] exp_resp);
    logic [WORD_W-1:0] data;
    logic [1:0]        resp;
    axil_read(addr, data, resp);
    check_value(resp, exp_resp, $sformatf("rresp at 0x%h", addr));
    check_value(data, exp, $sformatf("rdata at 0x%h", addr));
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic reset_outputs_low();
    int n;
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (reset && n < WAIT_MAX);
    if (reset) report_timeout("reset to be released");
    check_value(cmd_valid, 1'b0, "cmd_valid after reset");
    check_value(sys_reset, 1'b0, "sys_reset after reset");
    check_value(bvalid, 1'b0, "bvalid after reset");
    check_value(rvalid, 1'b0, "rvalid after reset");
    check_value(awready, 1'b0, "awready after reset");
    check_value(wready, 1'b0, "wready after reset");
    check_value(arready, 1'b0, "arready after reset");
  endtask

  task automatic arg_status_readback();
    logic [WORD_W-1:0] exp;
    for (int i = 0; i < ARG_NUM; i++) write_arg(i, $random(seed));
    for (int i = 0; i < ARG_NUM; i++) read_expect(ADDR_W'(ARG_BASE + 4 * i), arg_model[i],
                                                  RESP_OKAY);
    for (int i = 0; i < ARG_NUM; i++) begin
      if (i == 0) exp = arg_model[0];              // echo of arg 0
      else if (i <= STATE_NUM) exp = state[i-1];
      else exp = '0;
      read_expect(ADDR_W'(STATUS_BASE + 4 * i), exp, RESP_OKAY);
    end
  endtask

  task automatic strobe_and_unmapped();
    logic [WORD_W-1:0] new_word, mask;
    logic [3:0]        strb;
    logic [1:0]        resp;
    int unsigned       hs;
    strb     = 4'b0101;
    new_word = $random(seed);
    for (int b = 0; b < 4; b++) mask[b*8 +: 8] = {8{strb[b]}};
    axil_write(ADDR_W'(ARG_BASE + 4 * 5), new_word, strb, resp, hs);
    check_value(resp, RESP_OKAY, "bresp of strobed write");
    arg_model[5] = (arg_model[5] & ~mask) | (new_word & mask);
    read_expect(ADDR_W'(ARG_BASE + 4 * 5), arg_model[5], RESP_OKAY);
    axil_write(8'h30, $random(seed), 4'hf, resp, hs);
    check_value(resp, RESP_SLVERR, "bresp of unmapped write");
    for (int i = 0; i < ARG_NUM; i++) read_expect(ADDR_W'(ARG_BASE + 4 * i), arg_model[i],
                                                  RESP_OKAY);
    read_expect(8'h30, '0, RESP_SLVERR);
    read_expect(8'h60, '0, RESP_SLVERR);
    read_expect(CMD_OFFSET, '0, RESP_SLVERR);  // write-only register
  endtask

  // waits for the launch pulse and checks its timing and fields
  task automatic expect_launch(input int unsigned hs_cyc, input int delay,
                               input logic [CMD_W-1:0] code, input int unsigned pulses_before);
    int n;
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!cmd_valid && n < WAIT_MAX);
    if (!cmd_valid) report_timeout("cmd_valid");
    check_value(cyc - hs_cyc, delay + 2, "cycles from command write to cmd_valid");
    check_value(cmd, arg_model[ARG_CMD_IDX], "cmd_o at launch");
    check_value(data0, arg_model[ARG_DATA0_IDX], "data0_o at launch");
    check_value(data1, arg_model[ARG_DATA1_IDX], "data1_o at launch");
    check_value(cmd_code, code, "cmd_code_o at launch");
    repeat (delay + 10) @(posedge user_clk);
    check_value(pulse_cnt - pulses_before, 1, "number of cmd_valid pulses");
  endtask

  task automatic cmd_launch_timing(input int delay);
    logic [CMD_W-1:0] code;
    logic [1:0]       resp;
    int unsigned      hs, p0;
    for (int i = ARG_CMD_IDX; i <= ARG_DATA1_IDX; i++) write_arg(i, $random(seed));
    write_arg(ARG_DELAY_IDX, delay);
    code = CMD_W'($random(seed));
    p0   = pulse_cnt;
    axil_write(CMD_OFFSET, {24'h0, code}, 4'hf, resp, hs);
    check_value(resp, RESP_OKAY, "bresp of command write");
    expect_launch(hs, delay, code, p0);
  endtask

  task automatic cmd_reload();
    logic [CMD_W-1:0] code;
    logic [1:0]       resp;
    int unsigned      hs, p0;
    write_arg(ARG_DELAY_IDX, 12);
    p0 = pulse_cnt;
    axil_write(CMD_OFFSET, 32'h11, 4'hf, resp, hs);
    check_value(resp, RESP_OKAY, "bresp of first command write");
    write_arg(ARG_DELAY_IDX, 3);   // first countdown still running
    code = 8'h5a;
    axil_write(CMD_OFFSET, {24'h0, code}, 4'hf, resp, hs);
    check_value(resp, RESP_OKAY, "bresp of reload command write");
    expect_launch(hs, 3, code, p0);
  endtask

  task automatic watchdog_cycle();
    logic [1:0]  resp;
    int unsigned hs;
    int          n;
    axil_write(WDOG_OFFSET, 32'h2, 4'hf, resp, hs);   // start
    check_value(resp, RESP_OKAY, "bresp of watchdog start");
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!sys_reset && n < WDOG_LIMIT + WDOG_SLACK);
    if (!sys_reset) report_timeout("sys_reset after watchdog start");
    check_range(cyc - hs, WDOG_LIMIT, WDOG_LIMIT + WDOG_SLACK, "cycles until sys_reset");
    axil_write(WDOG_OFFSET, 32'h1, 4'hf, resp, hs);   // clear
    check_value(resp, RESP_OKAY, "bresp of watchdog clear");
    repeat (WDOG_LIMIT + WDOG_SLACK) begin
      @(posedge user_clk);
      check_value(sys_reset, 1'b0, "sys_reset after clear");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < STATE_NUM; i++) state[i] = $random(seed);
    for (int i = 0; i < ARG_NUM; i++) arg_model[i] = '0;

    reset_outputs_low();
    arg_status_readback();
    strobe_and_unmapped();
    cmd_launch_timing(5);
    cmd_launch_timing(0);
    cmd_reload();
    watchdog_cycle();

    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
